// File: project.f
+incdir+source
+incdir+testbench
source/ras_pkg.sv
source/sdp_ram.sv
source/ras.sv
source/ras_ckpt_queue.sv
source/ras_predictor_top.sv
testbench/ras_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the return address stack testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module ras_tb \
    -o ras_sim > sim.log 2>&1 || { echo "build failed, see sim.log"; exit 1; }

./obj_dir/ras_sim >> sim.log 2>&1

grep -q "Test FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }

echo "simulation passed"
exit 0

// File: source/ras.sv
`timescale 1ns/1ns
`include "ras_params.svh"

module ras (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     request,
    input  ras_pkg::ras_type_e       ras_type,
    input  logic [`VADDR_WIDTH-1:0]  target,
    input  logic                     squash,
    input  ras_pkg::ras_type_e       squash_type,
    input  logic [`VADDR_WIDTH-1:0]  squash_start_addr,
    input  logic [`OFFSET_WIDTH-1:0] squash_offset,
    input  ras_pkg::ras_ckpt_u       ckpt_restore,
    output ras_pkg::ras_ckpt_u       ckpt_now,
    output logic                     ras_en,
    output logic [`VADDR_WIDTH-1:0]  ras_pc
);

    import ras_pkg::*;

    logic [`RAS_WIDTH-1:0]   top;
    logic [`RAS_WIDTH-1:0]   bottom;
    logic                    tdir;
    logic                    bdir;
    logic                    empty;
    logic [`RAS_WIDTH-1:0]   top_m1;

    ras_ckpt_u               base;
    ras_ckpt_u               nxt;
    ras_type_e               op;
    logic                    base_full;
    logic                    base_empty;
    logic [`RAS_WIDTH:0]     top_inc;
    logic [`RAS_WIDTH:0]     top_dec;
    logic [`RAS_WIDTH:0]     bottom_inc;

    logic                    we;
    logic [`RAS_WIDTH-1:0]   waddr;
    logic [`VADDR_WIDTH-1:0] wdata;
    logic [`VADDR_WIDTH-1:0] squash_target;

    assign ckpt_now.f.top    = top;
    assign ckpt_now.f.tdir   = tdir;
    assign ckpt_now.f.bottom = bottom;
    assign ckpt_now.f.bdir   = bdir;

    assign empty  = (tdir == bdir) && (top == bottom);
    assign top_m1 = top - `RAS_WIDTH'd1;
    assign ras_en = ~empty;

    // a squash starts from the checkpoint, otherwise from the live pointers.
    assign base = squash ? ckpt_restore : ckpt_now;
    assign op   = squash ? squash_type : (request ? ras_type : NONE);

    assign base_full  = (base.f.tdir != base.f.bdir) && (base.f.top == base.f.bottom);
    assign base_empty = (base.f.tdir == base.f.bdir) && (base.f.top == base.f.bottom);

    // the direction bit sits above the pointer, so it toggles on every wrap.
    assign top_inc    = {base.f.tdir, base.f.top} + 1'b1;
    assign top_dec    = {base.f.tdir, base.f.top} - 1'b1;
    assign bottom_inc = {base.f.bdir, base.f.bottom} + 1'b1;

    always_comb begin
        nxt = base;
        case (op)
            POP: begin
                if (!base_empty) begin
                    {nxt.f.tdir, nxt.f.top} = top_dec;
                end
            end
            PUSH: begin
                {nxt.f.tdir, nxt.f.top} = top_inc;
                if (base_full) begin
                    {nxt.f.bdir, nxt.f.bottom} = bottom_inc; // oldest entry is dropped.
                end
            end
            default: nxt = base; // none and pop_push keep the pointers.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            top    <= '0;
            tdir   <= 1'b0;
            bottom <= '0;
            bdir   <= 1'b0;
        end else begin
            top    <= nxt.f.top;
            tdir   <= nxt.f.tdir;
            bottom <= nxt.f.bottom;
            bdir   <= nxt.f.bdir;
        end
    end

    // return address of a corrected call, the slot after the call itself.
    assign squash_target = squash_start_addr
                         + {{(`VADDR_WIDTH-`OFFSET_WIDTH-2){1'b0}}, squash_offset, 2'b00}
                         + `VADDR_WIDTH'd4;

    assign we    = op[1];
    assign waddr = (op == POP_PUSH) ? base.f.top - `RAS_WIDTH'd1 : base.f.top;
    assign wdata = squash ? squash_target : target;

    sdp_ram sdp_ram_i (
        .clk   (clk),
        .rst   (rst),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (top_m1),
        .rdata (ras_pc)
    );

endmodule

// File: source/ras_ckpt_queue.sv
`timescale 1ns/1ns
`include "ras_params.svh"

module ras_ckpt_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  request,
    input  logic                  squash,
    input  ras_pkg::ras_ckpt_u    ckpt_now,
    input  logic [`TAG_WIDTH-1:0] squash_tag,
    output logic [`TAG_WIDTH-1:0] req_tag,
    output ras_pkg::ras_ckpt_u    ckpt_restore
);

    import ras_pkg::*;

    logic [ras_ckpt_w-1:0] ckpt_mem [`CKPT_DEPTH];
    logic [`TAG_WIDTH-1:0] tag;
    logic                  record;

    // a request in a squash cycle is dropped and gets no checkpoint.
    assign record = request && !squash;

    always_ff @(posedge clk) begin
        if (record) begin
            ckpt_mem[tag] <= ckpt_now.raw; // pointers from before this request.
        end
    end

    // tag counter wraps around the table.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag <= '0;
        end else if (squash) begin
            tag <= squash_tag + `TAG_WIDTH'd1; // younger tags are freed.
        end else if (record) begin
            tag <= tag + `TAG_WIDTH'd1;
        end
    end

    assign req_tag          = tag;
    assign ckpt_restore.raw = ckpt_mem[squash_tag];

endmodule

// File: source/ras_params.svh
`ifndef RAS_PARAMS_SVH
`define RAS_PARAMS_SVH

// stack depth, must be a power of two.
`define RAS_SIZE 8
`define RAS_WIDTH 3

`define VADDR_WIDTH 32

// instruction slot within a fetch block.
`define OFFSET_WIDTH 3

// checkpoint tags.
`define TAG_WIDTH 4
`define CKPT_DEPTH (1 << `TAG_WIDTH)

`endif

// File: source/ras_pkg.sv
`include "ras_params.svh"

package ras_pkg;

    // upper bit set means the operation writes an entry.
    typedef enum logic [1:0] {
        NONE     = 2'b00,
        POP      = 2'b01,
        PUSH     = 2'b10,
        POP_PUSH = 2'b11
    } ras_type_e;

    localparam int ras_ckpt_w = 2 * `RAS_WIDTH + 2;

    typedef struct packed {
        logic [`RAS_WIDTH-1:0] top;
        logic                  tdir;
        logic [`RAS_WIDTH-1:0] bottom;
        logic                  bdir;
    } ras_ckpt_s;

    // the queue only stores the flat word, the stack decodes the fields.
    typedef union packed {
        logic [ras_ckpt_w-1:0] raw;
        ras_ckpt_s             f;
    } ras_ckpt_u;

endpackage

// File: source/ras_predictor_top.sv
`timescale 1ns/1ns
`include "ras_params.svh"

module ras_predictor_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     request,
    input  ras_pkg::ras_type_e       ras_type,
    input  logic [`VADDR_WIDTH-1:0]  target,
    input  logic                     squash,
    input  logic [`TAG_WIDTH-1:0]    squash_tag,
    input  ras_pkg::ras_type_e       squash_type,
    input  logic [`VADDR_WIDTH-1:0]  squash_start_addr,
    input  logic [`OFFSET_WIDTH-1:0] squash_offset,
    output logic [`TAG_WIDTH-1:0]    req_tag,
    output logic                     ras_en,
    output logic [`VADDR_WIDTH-1:0]  ras_pc
);

    import ras_pkg::*;

    ras_ckpt_u ckpt_now;
    ras_ckpt_u ckpt_restore;

    ras_ckpt_queue ras_ckpt_queue_i (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .squash       (squash),
        .ckpt_now     (ckpt_now),
        .squash_tag   (squash_tag),
        .req_tag      (req_tag),
        .ckpt_restore (ckpt_restore)
    );

    ras ras_i (
        .clk               (clk),
        .rst               (rst),
        .request           (request),
        .ras_type          (ras_type),
        .target            (target),
        .squash            (squash),
        .squash_type       (squash_type),
        .squash_start_addr (squash_start_addr),
        .squash_offset     (squash_offset),
        .ckpt_restore      (ckpt_restore),
        .ckpt_now          (ckpt_now),
        .ras_en            (ras_en),
        .ras_pc            (ras_pc)
    );

endmodule

// File: source/sdp_ram.sv
`timescale 1ns/1ns
`include "ras_params.svh"

module sdp_ram (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  logic [`RAS_WIDTH-1:0]   waddr,
    input  logic [`VADDR_WIDTH-1:0] wdata,
    input  logic [`RAS_WIDTH-1:0]   raddr,
    output logic [`VADDR_WIDTH-1:0] rdata
);

    logic [`VADDR_WIDTH-1:0] mem [`RAS_SIZE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RAS_SIZE; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read, a same-cycle write is seen after the edge.
    assign rdata = mem[raddr];

endmodule

// File: testbench/ras_tb_table.svh
`ifndef RAS_TB_TABLE_SVH
`define RAS_TB_TABLE_SVH

// req_row: name, operation, random target, target, expected ras_en, pc check, expected ras_pc.
// squash_row: name, request index, corrected operation, start address, offset,
// then the ignored request (strobe, operation, target) and the expected results.
task automatic load_table();
    // reset state, pop on the empty stack. request 0.
    idle_row("reset_idle", 1'b0, PC_SKIP, 32'h0);
    req_row("empty_pop", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);

    // requests 1 to 6.
    req_row("push3_a", PUSH, 1'b0, 32'h0000_1004, 1'b1, PC_LIT, 32'h0000_1004);
    req_row("push3_b", PUSH, 1'b0, 32'h0000_2008, 1'b1, PC_LIT, 32'h0000_2008);
    req_row("push3_c", PUSH, 1'b0, 32'h0000_300c, 1'b1, PC_LIT, 32'h0000_300c);
    req_row("pop3_a", POP, 1'b0, 32'h0, 1'b1, PC_LIT, 32'h0000_2008);
    req_row("pop3_b", POP, 1'b0, 32'h0, 1'b1, PC_LIT, 32'h0000_1004);
    req_row("pop3_c", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);

    // overflow with random targets, requests 7 to 25.
    repeat (`RAS_SIZE + 2) begin
        req_row("overflow_push", PUSH, 1'b1, 32'h0, 1'b1, PC_MODEL, 32'h0);
    end
    repeat (`RAS_SIZE - 1) begin
        req_row("overflow_pop", POP, 1'b0, 32'h0, 1'b1, PC_MODEL, 32'h0);
    end
    req_row("overflow_last_pop", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);
    req_row("overflow_extra_pop", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);

    // requests 26 to 30.
    req_row("pp_push_a", PUSH, 1'b0, 32'h0000_4000, 1'b1, PC_LIT, 32'h0000_4000);
    req_row("pp_push_b", PUSH, 1'b0, 32'h0000_5000, 1'b1, PC_LIT, 32'h0000_5000);
    req_row("pp_replace", POP_PUSH, 1'b0, 32'h0000_6000, 1'b1, PC_LIT, 32'h0000_6000);
    req_row("pp_pop_a", POP, 1'b0, 32'h0, 1'b1, PC_LIT, 32'h0000_4000);
    req_row("pp_pop_b", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);

    // corrected call, requests 31 to 36. request 32 is the one squashed.
    req_row("sqp_push_a", PUSH, 1'b0, 32'h0000_7000, 1'b1, PC_LIT, 32'h0000_7000);
    req_row("sqp_push_b", PUSH, 1'b0, 32'h0000_8000, 1'b1, PC_LIT, 32'h0000_8000);
    req_row("sqp_push_c", PUSH, 1'b0, 32'h0000_9000, 1'b1, PC_LIT, 32'h0000_9000);
    req_row("sqp_pop", POP, 1'b0, 32'h0, 1'b1, PC_LIT, 32'h0000_8000);
    squash_row("squash_push", 32, PUSH, 32'h0001_0000, 3'd3,
               1'b0, NONE, 32'h0, 1'b1, PC_LIT, 32'h0001_0010);
    req_row("sqp_pop_below", POP, 1'b0, 32'h0, 1'b1, PC_LIT, 32'h0000_7000);
    req_row("sqp_pop_last", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);

    // squash with pop and none, requests 37 to 44.
    req_row("sq6_push_a", PUSH, 1'b0, 32'h0000_a000, 1'b1, PC_LIT, 32'h0000_a000);
    req_row("sq6_push_b", PUSH, 1'b0, 32'h0000_b000, 1'b1, PC_LIT, 32'h0000_b000);
    req_row("sq6_push_c", PUSH, 1'b0, 32'h0000_c000, 1'b1, PC_LIT, 32'h0000_c000);
    squash_row("squash_pop", 39, POP, 32'h0, 3'd0,
               1'b1, PUSH, 32'h0000_d000, 1'b1, PC_LIT, 32'h0000_a000);
    req_row("sq6_push_e", PUSH, 1'b0, 32'h0000_e000, 1'b1, PC_LIT, 32'h0000_e000);
    req_row("sq6_push_f", PUSH, 1'b0, 32'h0000_f000, 1'b1, PC_LIT, 32'h0000_f000);
    squash_row("squash_none", 41, NONE, 32'h0, 3'd0,
               1'b1, POP, 32'h0, 1'b1, PC_LIT, 32'h0000_e000);
    req_row("sq6_pop_a", POP, 1'b0, 32'h0, 1'b1, PC_LIT, 32'h0000_a000);
    req_row("sq6_pop_b", POP, 1'b0, 32'h0, 1'b0, PC_SKIP, 32'h0);
    req_row("sq6_push_g", PUSH, 1'b0, 32'h0001_1000, 1'b1, PC_LIT, 32'h0001_1000);
    squash_row("squash_empty_pop", 44, POP, 32'h0, 3'd0,
               1'b0, NONE, 32'h0, 1'b0, PC_SKIP, 32'h0);
endtask

`endif

// File: testbench/ras_tb.sv
`timescale 1ns/1ns
`include "ras_params.svh"

module ras_tb;

    import ras_pkg::*;

    localparam int MAX_ROWS      = 64;
    localparam int MAX_REQS      = 64;
    localparam int RESET_TIMEOUT = 40;
    localparam int PC_SKIP       = 0;
    localparam int PC_LIT        = 1;
    localparam int PC_MODEL      = 2; // expected pc comes from the shadow stack.

    logic                     clk;
    logic                     rst;
    logic                     request;
    ras_type_e                ras_type;
    logic [`VADDR_WIDTH-1:0]  target;
    logic                     squash;
    logic [`TAG_WIDTH-1:0]    squash_tag;
    ras_type_e                squash_type;
    logic [`VADDR_WIDTH-1:0]  squash_start_addr;
    logic [`OFFSET_WIDTH-1:0] squash_offset;
    logic [`TAG_WIDTH-1:0]    req_tag;
    logic                     ras_en;
    logic [`VADDR_WIDTH-1:0]  ras_pc;

    string                    row_name     [MAX_ROWS];
    logic                     row_req      [MAX_ROWS];
    ras_type_e                row_type     [MAX_ROWS];
    logic                     row_rnd      [MAX_ROWS];
    logic [`VADDR_WIDTH-1:0]  row_target   [MAX_ROWS];
    logic                     row_sq       [MAX_ROWS];
    int                       row_sq_idx   [MAX_ROWS];
    ras_type_e                row_sq_type  [MAX_ROWS];
    logic [`VADDR_WIDTH-1:0]  row_sq_start [MAX_ROWS];
    logic [`OFFSET_WIDTH-1:0] row_sq_off   [MAX_ROWS];
    logic                     row_en       [MAX_ROWS];
    int                       row_pc_mode  [MAX_ROWS];
    logic [`VADDR_WIDTH-1:0]  row_pc       [MAX_ROWS];
    int                       num_rows;

    // shadow stack, entry 0 is the oldest.
    logic [`VADDR_WIDTH-1:0]  shadow [`RAS_SIZE];
    int                       depth;
    logic [`VADDR_WIDTH-1:0]  snap [MAX_REQS][`RAS_SIZE];
    int                       snap_depth [MAX_REQS];
    logic [`TAG_WIDTH-1:0]    snap_tag [MAX_REQS];
    int                       num_reqs;
    logic [`TAG_WIDTH-1:0]    tag_model;
    logic [31:0]              lcg_state;

    ras_predictor_top ras_predictor_top_i (
        .clk               (clk),
        .rst               (rst),
        .request           (request),
        .ras_type          (ras_type),
        .target            (target),
        .squash            (squash),
        .squash_tag        (squash_tag),
        .squash_type       (squash_type),
        .squash_start_addr (squash_start_addr),
        .squash_offset     (squash_offset),
        .req_tag           (req_tag),
        .ras_en            (ras_en),
        .ras_pc            (ras_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_en(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s ras_en expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic compare_pc(input string name, input logic [`VADDR_WIDTH-1:0] exp,
                              input logic [`VADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s ras_pc expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_tag(input string name, input logic [`TAG_WIDTH-1:0] exp,
                               input logic [`TAG_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s req_tag expected %0d actual %0d", name, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[31:2], 2'b00}; // word aligned return address.
    endfunction

    task automatic push_entry(input logic [`VADDR_WIDTH-1:0] addr);
        if (depth == `RAS_SIZE) begin
            for (int i = 0; i < `RAS_SIZE - 1; i++) begin
                shadow[i] = shadow[i+1]; // the oldest entry falls off.
            end
            depth = depth - 1;
        end
        shadow[depth] = addr;
        depth = depth + 1;
    endtask

    task automatic apply_op(input ras_type_e op, input logic [`VADDR_WIDTH-1:0] addr);
        case (op)
            PUSH: push_entry(addr);
            POP: begin
                if (depth > 0) depth = depth - 1;
            end
            POP_PUSH: begin
                if (depth > 0) shadow[depth-1] = addr;
            end
            default: ;
        endcase
    endtask

    task automatic save_snapshot(input int idx);
        for (int i = 0; i < `RAS_SIZE; i++) begin
            snap[idx][i] = shadow[i];
        end
        snap_depth[idx] = depth;
        snap_tag[idx]   = tag_model;
    endtask

    task automatic restore_snapshot(input int idx);
        for (int i = 0; i < `RAS_SIZE; i++) begin
            shadow[i] = snap[idx][i];
        end
        depth = snap_depth[idx];
    endtask

    task automatic store_row(input string name, input logic req, input ras_type_e op,
                             input logic rnd, input logic [`VADDR_WIDTH-1:0] tgt,
                             input logic sq, input int sq_idx, input ras_type_e sq_op,
                             input logic [`VADDR_WIDTH-1:0] start,
                             input logic [`OFFSET_WIDTH-1:0] off, input logic en,
                             input int mode, input logic [`VADDR_WIDTH-1:0] pc);
        if (num_rows >= MAX_ROWS) begin
            abort_run("the stimulus table has more rows than the row storage holds");
        end else begin
            row_name[num_rows]     = name;
            row_req[num_rows]      = req;
            row_type[num_rows]     = op;
            row_rnd[num_rows]      = rnd;
            row_target[num_rows]   = tgt;
            row_sq[num_rows]       = sq;
            row_sq_idx[num_rows]   = sq_idx;
            row_sq_type[num_rows]  = sq_op;
            row_sq_start[num_rows] = start;
            row_sq_off[num_rows]   = off;
            row_en[num_rows]       = en;
            row_pc_mode[num_rows]  = mode;
            row_pc[num_rows]       = pc;
            num_rows               = num_rows + 1;
        end
    endtask

    task automatic req_row(input string name, input ras_type_e op, input logic rnd,
                           input logic [`VADDR_WIDTH-1:0] tgt, input logic en,
                           input int mode, input logic [`VADDR_WIDTH-1:0] pc);
        store_row(name, 1'b1, op, rnd, tgt, 1'b0, 0, NONE, 32'h0, 3'd0, en, mode, pc);
    endtask

    task automatic squash_row(input string name, input int idx, input ras_type_e sq_op,
                              input logic [`VADDR_WIDTH-1:0] start,
                              input logic [`OFFSET_WIDTH-1:0] off, input logic req,
                              input ras_type_e op, input logic [`VADDR_WIDTH-1:0] tgt,
                              input logic en, input int mode,
                              input logic [`VADDR_WIDTH-1:0] pc);
        store_row(name, req, op, 1'b0, tgt, 1'b1, idx, sq_op, start, off, en, mode, pc);
    endtask

    task automatic idle_row(input string name, input logic en, input int mode,
                            input logic [`VADDR_WIDTH-1:0] pc);
        store_row(name, 1'b0, NONE, 1'b0, 32'h0, 1'b0, 0, NONE, 32'h0, 3'd0, en, mode, pc);
    endtask

    `include "ras_tb_table.svh"

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("reset was still asserted after the reset timeout");
            end
        end
        #1;
    endtask

    task automatic apply_row(input int r);
        logic [`VADDR_WIDTH-1:0] addr;
        logic [`VADDR_WIDTH-1:0] fixed_addr;
        int                      idx;
        addr = row_target[r];
        idx  = row_sq_idx[r];
        if (row_sq[r]) begin
            if (idx < 0 || idx >= num_reqs) begin
                abort_run($sformatf("row %0d squashes request %0d, which was never sent",
                                    r, idx));
            end
            restore_snapshot(idx);
            tag_model  = snap_tag[idx] + `TAG_WIDTH'd1;
            // return address is the slot after the call.
            fixed_addr = row_sq_start[r] + (`VADDR_WIDTH'(row_sq_off[r]) << 2)
                       + `VADDR_WIDTH'd4;
            apply_op(row_sq_type[r], fixed_addr);
        end else if (row_req[r]) begin
            if (num_reqs >= MAX_REQS) begin
                abort_run("more requests were sent than the checkpoint model holds");
            end
            if (row_rnd[r]) addr = next_rand();
            save_snapshot(num_reqs);
            num_reqs  = num_reqs + 1;
            tag_model = tag_model + `TAG_WIDTH'd1;
            apply_op(row_type[r], addr);
        end
        request           = row_req[r];
        ras_type          = row_type[r];
        target            = addr;
        squash            = row_sq[r];
        squash_tag        = row_sq[r] ? snap_tag[idx] : '0;
        squash_type       = row_sq_type[r];
        squash_start_addr = row_sq_start[r];
        squash_offset     = row_sq_off[r];
    endtask

    task automatic check_row(input int r);
        string name;
        name = $sformatf("%s (row %0d)", row_name[r], r);
        compare_en(name, row_en[r], ras_en);
        compare_tag(name, tag_model, req_tag);
        if (row_pc_mode[r] == PC_LIT) begin
            compare_pc(name, row_pc[r], ras_pc);
        end else if (row_pc_mode[r] == PC_MODEL) begin
            if (depth == 0) abort_run($sformatf("%s expects a stacked address but none", name));
            else compare_pc(name, shadow[depth-1], ras_pc);
        end
    endtask

    initial begin
        request           = 1'b0;
        ras_type          = NONE;
        target            = '0;
        squash            = 1'b0;
        squash_tag        = '0;
        squash_type       = NONE;
        squash_start_addr = '0;
        squash_offset     = '0;
        depth             = 0;
        num_reqs          = 0;
        num_rows          = 0;
        tag_model         = '0;
        lcg_state         = 32'h972e_b5f9;
        load_table();
        wait_reset_done();
        for (int r = 0; r < num_rows; r++) begin
            apply_row(r);
            @(posedge clk);
            #1;
            check_row(r); // state after the edge that took this row.
        end
        $display("Test OK");
        $finish;
    end

endmodule
